//--- lsu_pkg.sv
// the load ops keep their funct3 codes and the store ops take the three codes loads leave unused
package lsu_pkg;

    // entries in each of the request and response queues
    localparam int LSU_QUEUE_DEPTH = 4;

    // the low two bits of a load give its size, bit 2 marks zero extension
    typedef enum logic [2:0]
    {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } lsu_op_e;

    // one request from the execute side
    typedef struct packed
    {
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // one result back to the pipeline, rdata reads as zero for a store
    typedef struct packed
    {
        logic        is_store;
        logic [31:0] addr;
        logic [31:0] rdata;
    } lsu_rsp_t;

endpackage

//--- dbus_pkg.sv
// the bus carries whole words, so byte addressing stops at the load/store unit and RAM depth is 2**DBUS_AW
package dbus_pkg;

    // width of the word address on the bus
    localparam int DBUS_AW    = 8;
    localparam int DBUS_DW    = 32;
    localparam int DBUS_MW    = DBUS_DW / 8;
    localparam int DBUS_DEPTH = 1 << DBUS_AW;

    typedef logic [DBUS_DW-1:0] dbus_data_t;

    // payload that stays stable while req is high
    typedef struct packed
    {
        logic [DBUS_AW-1:0] addr;
        logic               we;
        logic [DBUS_MW-1:0] mask;
        dbus_data_t         wdata;
    } dbus_req_t;

endpackage

//--- lsu_lane.sv
// purely combinational, ignores misalignment: halfwords use address bit 1 only and loads keep mask 1111
`timescale 1ns/1ps

module lsu_lane (
    input  lsu_pkg::lsu_op_e op_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      wdata_i,
    input  logic [31:0]      rdata_i,
    output logic [3:0]       mask_o,
    output logic [31:0]      wdata_o,
    output logic             is_store_o,
    output logic [31:0]      rdata_o
);
    import lsu_pkg::*;

    logic [3:0]  sb_mask;
    logic [3:0]  sh_mask;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // lane selects taken from the low address bits
    assign sb_mask  = 4'b0001 << addr_i[1:0];
    assign sh_mask  = addr_i[1] ? 4'b1100 : 4'b0011;
    assign byte_sel = rdata_i[{addr_i[1:0], 3'b000} +: 8];
    assign half_sel = addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    assign is_store_o = (op_i == SB) || (op_i == SH) || (op_i == SW);

    always_comb
    begin
        case (op_i)
            SB:
            begin
                mask_o = sb_mask;
            end
            SH:
            begin
                mask_o = sh_mask;
            end
            default:
            begin
                mask_o = 4'b1111;
            end
        endcase
    end

    // store data moves up to the byte lane that the mask enables
    always_comb
    begin
        case (op_i)
            SB:
            begin
                wdata_o = wdata_i << {addr_i[1:0], 3'b000};
            end
            SH:
            begin
                wdata_o = addr_i[1] ? (wdata_i << 16) : wdata_i;
            end
            default:
            begin
                wdata_o = wdata_i;
            end
        endcase
    end

    always_comb
    begin
        case (op_i)
            LB:
            begin
                rdata_o = {{24{byte_sel[7]}}, byte_sel};
            end
            LBU:
            begin
                rdata_o = {24'd0, byte_sel};
            end
            LH:
            begin
                rdata_o = {{16{half_sel[15]}}, half_sel};
            end
            LHU:
            begin
                rdata_o = {16'd0, half_sel};
            end
            default:
            begin
                // LW and the stores see the raw word
                rdata_o = rdata_i;
            end
        endcase
    end

endmodule

//--- lsu_fifo.sv
// fall-through head, a push while full or a pop while empty is dropped without any flag
`timescale 1ns/1ps

module lsu_fifo #(
    parameter type T = lsu_pkg::lsu_req_t
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic push_i,
    input  T     push_data_i,
    output logic full_o,
    input  logic pop_i,
    output T     pop_data_o,
    output logic empty_o
);
    import lsu_pkg::*;

    localparam int PTR_W = (LSU_QUEUE_DEPTH > 1) ? $clog2(LSU_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(LSU_QUEUE_DEPTH + 1);

    T                 mem_q [LSU_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // wraps without needing a power of two depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LSU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o     = (count_q == CNT_W'(LSU_QUEUE_DEPTH));
    assign empty_o    = (count_q == '0);
    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && !empty_o;
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (do_pop)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem_q[wr_ptr_q] <= push_data_i;
    end

endmodule

//--- lsu_ctrl.sv
// one bus access at a time, 4 cycles from pop to next pop with a responder that acks one edge after req
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_empty_i,
    output logic                 req_pop_o,
    input  lsu_pkg::lsu_req_t    req_data_i,
    input  logic                 rsp_full_i,
    output logic                 rsp_push_o,
    output lsu_pkg::lsu_rsp_t    rsp_data_o,
    output logic                 dbus_req_o,
    output dbus_pkg::dbus_req_t  dbus_req_pld_o,
    input  logic                 dbus_ack_i,
    input  dbus_pkg::dbus_data_t dbus_rdata_i
);
    import lsu_pkg::*;
    import dbus_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        REQ,
        RELEASE,
        WAIT_ACK_LOW
    } state_e;

    state_e             state_q;
    state_e             state_d;
    lsu_req_t           cur_q;
    logic               can_pop;
    logic [DBUS_MW-1:0] lane_mask;
    logic [31:0]        lane_wdata;
    logic [31:0]        lane_rdata;
    logic               lane_is_store;

    // a new access starts only once the previous ack has gone low
    assign can_pop   = (state_q == IDLE) || ((state_q == WAIT_ACK_LOW) && !dbus_ack_i);
    assign req_pop_o = can_pop && !req_empty_i && !rsp_full_i;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (req_pop_o)
                    state_d = REQ;
            end
            REQ:
            begin
                if (dbus_ack_i)
                    state_d = RELEASE;
            end
            RELEASE:
            begin
                state_d = WAIT_ACK_LOW;
            end
            default:
            begin
                if (!dbus_ack_i)
                    state_d = req_pop_o ? REQ : IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i)
    begin
        if (req_pop_o)
            cur_q <= req_data_i;
    end

    lsu_lane i_lane (
        .op_i       (cur_q.op),
        .addr_i     (cur_q.addr),
        .wdata_i    (cur_q.wdata),
        .rdata_i    (dbus_rdata_i),
        .mask_o     (lane_mask),
        .wdata_o    (lane_wdata),
        .is_store_o (lane_is_store),
        .rdata_o    (lane_rdata)
    );

    // req is the REQ state itself, so it leaves on the edge after ack
    assign dbus_req_o           = (state_q == REQ);
    assign dbus_req_pld_o.addr  = cur_q.addr[DBUS_AW+1:2];
    assign dbus_req_pld_o.we    = lane_is_store;
    assign dbus_req_pld_o.mask  = lane_mask;
    assign dbus_req_pld_o.wdata = lane_wdata;

    assign rsp_push_o          = (state_q == REQ) && dbus_ack_i;
    assign rsp_data_o.is_store = lane_is_store;
    assign rsp_data_o.addr     = cur_q.addr;
    assign rsp_data_o.rdata    = lane_is_store ? 32'd0 : lane_rdata;

endmodule

//--- data_ram.sv
// storage powers up undefined, only the ack flop resets and read data holds until the next read
`timescale 1ns/1ps

module data_ram (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 dbus_req_i,
    input  dbus_pkg::dbus_req_t  dbus_req_pld_i,
    output logic                 dbus_ack_o,
    output dbus_pkg::dbus_data_t dbus_rdata_o
);
    import dbus_pkg::*;

    dbus_data_t mem_q [DBUS_DEPTH];
    dbus_data_t rdata_q;
    logic       ack_q;
    logic       access;

    // the access happens once, on the edge that raises ack
    assign access = dbus_req_i && !ack_q;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            if (access)
                ack_q <= 1'b1;
            else if (!dbus_req_i)
                ack_q <= 1'b0;
        end
    end

    // byte enables let a partial store leave the other lanes alone
    always_ff @(posedge clk_i)
    begin
        if (access && dbus_req_pld_i.we)
        begin
            for (int b = 0; b < DBUS_MW; b++)
            begin
                if (dbus_req_pld_i.mask[b])
                    mem_q[dbus_req_pld_i.addr][b*8 +: 8] <= dbus_req_pld_i.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (access && !dbus_req_pld_i.we)
            rdata_q <= mem_q[dbus_req_pld_i.addr];
    end

    assign dbus_ack_o   = ack_q;
    assign dbus_rdata_o = rdata_q;

endmodule

//--- mem_stage_top.sv
// no flush or stall input and no traps; with empty queues a result shows 3 edges after acceptance
`timescale 1ns/1ps

module mem_stage_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output lsu_pkg::lsu_rsp_t rsp_o,
    input  logic              rsp_ready_i
);
    import lsu_pkg::*;
    import dbus_pkg::*;

    logic       req_full;
    logic       req_empty;
    logic       req_pop;
    lsu_req_t   req_head;
    logic       rsp_full;
    logic       rsp_empty;
    logic       rsp_push;
    lsu_rsp_t   rsp_new;
    logic       dbus_req;
    dbus_req_t  dbus_req_pld;
    logic       dbus_ack;
    dbus_data_t dbus_rdata;

    assign req_ready_o = ~req_full;
    assign rsp_valid_o = ~rsp_empty;

    lsu_fifo #(.T(lsu_req_t)) i_req_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (req_valid_i),
        .push_data_i (req_i),
        .full_o      (req_full),
        .pop_i       (req_pop),
        .pop_data_o  (req_head),
        .empty_o     (req_empty)
    );

    lsu_ctrl i_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_empty_i    (req_empty),
        .req_pop_o      (req_pop),
        .req_data_i     (req_head),
        .rsp_full_i     (rsp_full),
        .rsp_push_o     (rsp_push),
        .rsp_data_o     (rsp_new),
        .dbus_req_o     (dbus_req),
        .dbus_req_pld_o (dbus_req_pld),
        .dbus_ack_i     (dbus_ack),
        .dbus_rdata_i   (dbus_rdata)
    );

    lsu_fifo #(.T(lsu_rsp_t)) i_rsp_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (rsp_push),
        .push_data_i (rsp_new),
        .full_o      (rsp_full),
        .pop_i       (rsp_ready_i),
        .pop_data_o  (rsp_o),
        .empty_o     (rsp_empty)
    );

    data_ram i_ram (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .dbus_req_i     (dbus_req),
        .dbus_req_pld_i (dbus_req_pld),
        .dbus_ack_o     (dbus_ack),
        .dbus_rdata_o   (dbus_rdata)
    );

endmodule

//--- mem_stage_sva.sv
// checks only the local data bus and the response port, the queues inside are not observed
`timescale 1ns/1ps

module mem_stage_sva (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              dbus_req_i,
    input logic              dbus_ack_i,
    input logic              rsp_valid_i,
    input logic              rsp_ready_i,
    input lsu_pkg::lsu_rsp_t rsp_i
);

    // once raised, req waits for the responder
    req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dbus_req_i && !dbus_ack_i) |=> dbus_req_i)
        else $error("dbus req fell before ack arrived");

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(dbus_ack_i) |-> $past(dbus_req_i))
        else $error("dbus ack rose without a pending req");

    // phase 4 must finish before the next access starts
    no_req_during_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(dbus_req_i) |-> !dbus_ack_i)
        else $error("dbus req rose again while ack was still high");

    rsp_stable_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_i && !rsp_ready_i) |=> $stable(rsp_i))
        else $error("rsp_o changed while stalled");

endmodule

bind mem_stage_top mem_stage_sva i_sva (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dbus_req_i  (dbus_req),
    .dbus_ack_i  (dbus_ack),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o)
);

//--- tb_mem_stage.sv
// RAM powers up undefined so every load reads a word stored earlier; addresses stay below 1 KiB
`timescale 1ns/1ps

module tb_mem_stage;
    import lsu_pkg::*;
    import dbus_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int REF_BYTES   = 4 * DBUS_DEPTH;
    // longer than one bus access, so a gap between two pops is not taken for a stall
    localparam int STALL_QUIET = 8;

    logic        clk_i;
    logic        rst_n_i;
    logic        req_valid_i;
    lsu_req_t    req_i;
    logic        req_ready_o;
    logic        rsp_valid_o;
    lsu_rsp_t    rsp_o;
    logic        rsp_ready_i;

    logic [7:0]  ref_mem [REF_BYTES];
    logic [15:0] lfsr_q;
    lsu_rsp_t    exp_q [$];
    lsu_rsp_t    got_q [$];
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          test_fail_cnt;

    mem_stage_top i_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    always #2 clk_i = ~clk_i;

    // every response handed over on a valid/ready edge
    always @(posedge clk_i)
    begin
        if (rst_n_i && rsp_valid_o && rsp_ready_i)
            got_q.push_back(rsp_o);
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("FAIL %0d ns: %s", $time, msg);
    endtask

    // little endian bytes; halfwords ignore address bit 0
    function automatic logic [31:0] model_load(input lsu_op_e op, input logic [31:0] addr);
        int          w;
        int          h;
        logic [7:0]  by;
        logic [15:0] hw;
        w  = int'({addr[9:2], 2'b00});
        h  = int'({addr[9:1], 1'b0});
        by = ref_mem[int'(addr[9:0])];
        hw = {ref_mem[h + 1], ref_mem[h]};
        case (op)
            LB:
                return {{24{by[7]}}, by};
            LBU:
                return {24'd0, by};
            LH:
                return {{16{hw[15]}}, hw};
            LHU:
                return {16'd0, hw};
            default:
                return {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
        endcase
    endfunction

    task automatic model_access(input lsu_op_e op, input logic [31:0] addr,
                                input logic [31:0] data);
        lsu_rsp_t exp;
        int       w;
        int       h;
        w            = int'({addr[9:2], 2'b00});
        h            = int'({addr[9:1], 1'b0});
        exp.addr     = addr;
        exp.is_store = (op == SB) || (op == SH) || (op == SW);
        exp.rdata    = '0;
        case (op)
            SB:
                ref_mem[int'(addr[9:0])] = data[7:0];
            SH:
            begin
                ref_mem[h]     = data[7:0];
                ref_mem[h + 1] = data[15:8];
            end
            SW:
            begin
                for (int k = 0; k < 4; k++)
                    ref_mem[w + k] = data[8*k +: 8];
            end
            default:
                exp.rdata = model_load(op, addr);
        endcase
        exp_q.push_back(exp);
    endtask

    task automatic issue_request(input lsu_op_e op, input logic [31:0] addr,
                                 input logic [31:0] data);
        int n;
        model_access(op, addr, data);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_i       <= '{op: op, addr: addr, wdata: data};
        n = 0;
        do
        begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("request was never accepted");
        end
        while (!req_ready_o);
        req_valid_i <= 1'b0;
    endtask

    task automatic drain_and_check(input string name);
        int n;
        n = 0;
        while (got_q.size() < exp_q.size())
        begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run($sformatf("%s is still missing responses", name));
        end
        // a quiet stretch exposes duplicated responses
        repeat (8) @(negedge clk_i);
        check_cnt++;
        if (got_q.size() != exp_q.size())
            report_mismatch($sformatf("%s: got %0d responses, expected %0d", name,
                                      got_q.size(), exp_q.size()));
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
        begin
            check_cnt++;
            if (got_q[i] !== exp_q[i])
                report_mismatch($sformatf("%s rsp %0d: store %b addr %h data %h, exp %b %h %h",
                    name, i, got_q[i].is_store, got_q[i].addr, got_q[i].rdata,
                    exp_q[i].is_store, exp_q[i].addr, exp_q[i].rdata));
        end
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        test_cnt++;
        if (err_cnt != errs_at_start)
        begin
            test_fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_at_start);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic check_after_reset();
        int e0;
        e0 = err_cnt;
        @(negedge clk_i);
        check_cnt += 2;
        if (rsp_valid_o !== 1'b0)
            report_mismatch("rsp_valid_o is not low after reset");
        if (req_ready_o !== 1'b1)
            report_mismatch("req_ready_o is not high after reset");
        close_test("after_reset", e0);
    endtask

    task automatic word_round_trip();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < 6; i++)
            issue_request(SW, 32'h20 + 32'(i) * 32'h24, rand_bits(32));
        for (int i = 0; i < 6; i++)
            issue_request(LW, 32'h20 + 32'(i) * 32'h24, '0);
        drain_and_check("word_round_trip");
        close_test("word_round_trip", e0);
    endtask

    // full random words go in, so the upper store bits must be masked off
    task automatic merge_partial_stores();
        int e0;
        e0 = err_cnt;
        issue_request(SW, 32'h200, rand_bits(32));
        for (int k = 0; k < 4; k++)
        begin
            issue_request(SB, 32'h200 + 32'(k), rand_bits(32));
            issue_request(LW, 32'h200, '0);
        end
        issue_request(SH, 32'h200, rand_bits(32));
        issue_request(LW, 32'h200, '0);
        issue_request(SH, 32'h202, rand_bits(32));
        issue_request(LW, 32'h200, '0);
        issue_request(SH, 32'h203, rand_bits(32));
        issue_request(LW, 32'h200, '0);
        drain_and_check("merge_partial_stores");
        close_test("merge_partial_stores", e0);
    endtask

    task automatic load_extension();
        int          e0;
        logic [31:0] words [3];
        logic [31:0] a;
        e0       = err_cnt;
        words[0] = 32'h8A7B_F15C;
        words[1] = 32'h6C93_2EA5;
        words[2] = rand_bits(32);
        for (int w = 0; w < 3; w++)
        begin
            a = 32'h300 + 32'(4 * w);
            issue_request(SW, a, words[w]);
            for (int k = 0; k < 4; k++)
            begin
                issue_request(LB, a + 32'(k), '0);
                issue_request(LBU, a + 32'(k), '0);
                issue_request(LH, a + 32'(k), '0);
                issue_request(LHU, a + 32'(k), '0);
            end
        end
        drain_and_check("load_extension");
        close_test("load_extension", e0);
    endtask

    // even slots store a fresh word, odd slots read it back
    function automatic lsu_req_t stall_request(input int i);
        lsu_req_t r;
        r.addr = 32'h380 + 32'(4 * (i / 2));
        if (i % 2 == 0)
        begin
            r.op    = SW;
            r.wdata = rand_bits(32);
        end
        else
        begin
            r.op    = LW;
            r.wdata = '0;
        end
        return r;
    endfunction

    task automatic backpressure_ordering();
        int       e0;
        int       n;
        int       accepted;
        int       low_run;
        lsu_req_t cand;
        e0       = err_cnt;
        accepted = 0;
        low_run  = 0;
        n        = 0;
        cand     = stall_request(0);
        @(posedge clk_i);
        rsp_ready_i <= 1'b0;
        req_valid_i <= 1'b1;
        req_i       <= cand;
        // keep offering until both queues are full and req_ready_o stays low
        do
        begin
            @(posedge clk_i);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("req_ready_o never stayed low while responses were held back");
            if (req_ready_o)
            begin
                model_access(cand.op, cand.addr, cand.wdata);
                accepted++;
                cand = stall_request(accepted);
                req_i <= cand;
                low_run = 0;
            end
            else
                low_run++;
        end
        while (low_run < STALL_QUIET);
        req_valid_i <= 1'b0;
        repeat (6) @(negedge clk_i);
        check_cnt += 3;
        if (accepted != 2 * LSU_QUEUE_DEPTH)
            report_mismatch($sformatf("%0d requests taken before stall, expected %0d",
                                      accepted, 2 * LSU_QUEUE_DEPTH));
        if (req_ready_o !== 1'b0)
            report_mismatch("req_ready_o rose again while responses were held back");
        if (rsp_valid_o !== 1'b1)
            report_mismatch("rsp_valid_o is low while responses are held back");
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        drain_and_check("backpressure_ordering");
        close_test("backpressure_ordering", e0);
    endtask

    initial
    begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        req_valid_i   = 1'b0;
        req_i         = '0;
        rsp_ready_i   = 1'b0;
        lfsr_q        = 16'd16584;
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        check_after_reset();
        @(posedge clk_i);
        rsp_ready_i <= 1'b1;
        word_round_trip();
        merge_partial_stores();
        load_extension();
        backpressure_ordering();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- mem_stage.f
lsu_pkg.sv
dbus_pkg.sv
lsu_lane.sv
lsu_fifo.sv
lsu_ctrl.sv
data_ram.sv
mem_stage_top.sv
mem_stage_sva.sv
tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - lsu_pkg.sv
      - dbus_pkg.sv
      - lsu_lane.sv
      - lsu_fifo.sv
      - lsu_ctrl.sv
      - data_ram.sv
      - mem_stage_top.sv
  - target: test
    files:
      - mem_stage_sva.sv
      - tb_mem_stage.sv
